// File: masked_pwm.f
hw/masked_pwm_pkg.sv
hw/mod_mult.sv
hw/masked_mult.sv
hw/masked_add.sv
hw/masked_pwm.sv
hw/pwm_top.sv
tests/masked_pwm_tb.sv

// File: tests/pwm_tests.dat
// columns: mode (0 plain multiply, 1 accumulate), u, v, w, expected result mod q
// expected is u*v mod q in mode 0 and (u*v + w) mod q in mode 1, all hex
0 000000 000000 000000 000000
0 000001 000001 000000 000001
0 000002 000003 000005 000006
1 000002 000003 000005 00000B
0 7FE000 7FE000 7FE000 000001
1 7FE000 7FE000 7FE000 000000
1 7FE000 000001 000001 000000
1 7FE000 000002 000000 7FDFFF
0 000000 7FE000 000007 000000
1 000000 000000 7FE000 7FE000
1 000001 7FE000 000002 000001
0 001000 001000 000000 003FFE
1 001000 000800 7FC002 000000
1 001000 001000 7FE000 003FFD
0 400000 000002 000000 001FFF
1 400000 400000 200000 0037FE
0 000003 7FE000 000000 7FDFFE
1 7FDFFF 7FDFFF 000010 000014
0 000123 000456 000999 04EDC2
1 000123 000456 000999 04F75B
1 7FE000 7FE000 000000 000001
0 000001 7FE000 000000 7FE000
1 001FFF 001FFF 7FE000 00BFF8
1 000005 000007 7FDFFF 000021
0 7FE000 000002 000001 7FDFFF
1 000800 000800 3FE001 000000

// File: tests/masked_pwm_tb.sv
// testbench for the masked pointwise-multiply unit, vectors from a data file
`default_nettype none

module masked_pwm_tb;

    // vector file shape, five hex columns per operation
    localparam int n_vec = 26;
    localparam int n_cols = 5;
    localparam int clk_period = 20;
    localparam int q_int = masked_pwm_pkg::q_mod;

    // vector 15 is repeated under fresh masks, vector 23 follows the zeroize
    localparam int mask_vec = 15;
    localparam int mask_reps = 4;
    localparam int zero_vec = 23;

    // run limit in cycles, scaled with the number of vectors
    localparam int limit_cycles = (n_vec + 20) * masked_pwm_pkg::pwm_lat;

    logic clk = 1'b0;
    logic reset_n;
    logic zeroize;
    logic in_valid;
    logic accumulate;
    logic [masked_pwm_pkg::coef_w-1:0] u0;
    logic [masked_pwm_pkg::coef_w-1:0] u1;
    logic [masked_pwm_pkg::coef_w-1:0] v0;
    logic [masked_pwm_pkg::coef_w-1:0] v1;
    logic [masked_pwm_pkg::coef_w-1:0] w0;
    logic [masked_pwm_pkg::coef_w-1:0] w1;
    logic [masked_pwm_pkg::coef_w-1:0] rnd0;
    logic [masked_pwm_pkg::coef_w-1:0] rnd1;
    logic out_valid;
    logic [masked_pwm_pkg::coef_w-1:0] res0;
    logic [masked_pwm_pkg::coef_w-1:0] res1;

    logic [23:0] vec_mem [0:n_vec*n_cols-1];
    logic [31:0] rng_state = 32'h9792;
    int cycle = 0;

    // in-flight items in issue order, one entry per expected out_valid
    int exp_q[$];
    int stamp_q[$];
    int tag_q[$];
    int vec_q[$];

    // output shares of the repeated vector, indexed by repetition
    int mask_res0 [mask_reps];
    int mask_res1 [mask_reps];

    int n_checks = 0;
    int value_errs = 0;
    int timing_errs = 0;
    int other_errs = 0;

    pwm_top dut_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .in_valid(in_valid),
        .accumulate(accumulate),
        .u0(u0),
        .u1(u1),
        .v0(v0),
        .v1(v1),
        .w0(w0),
        .w1(w1),
        .rnd0(rnd0),
        .rnd1(rnd1),
        .out_valid(out_valid),
        .res0(res0),
        .res1(res1)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // 32-bit xorshift step, shifts 13, 17 and 5
    function automatic logic [31:0] next_xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = next_xorshift(rng_state);
        r = rng_state;
    endtask

    // splits x into a random share s0 below q and s1 = (x - s0) mod q
    task automatic split_share(input int x, output int s0, output int s1);
        logic [31:0] r;
        draw_random(r);
        s0 = r[22:0];
        if (s0 >= q_int) begin
            s0 = s0 - q_int;
        end
        s1 = (x >= s0) ? x - s0 : x + q_int - s0;
    endtask

    // strobes vector idx on the next edge; tag >= 0 keeps its output shares
    // items that zeroize will drop are sent with keep low and never queued
    task automatic send_op(input int idx, input int tag, input bit keep);
        masked_pwm_pkg::pwm_mode_e mode;
        logic [31:0] ra;
        logic [31:0] rb;
        int us0;
        int us1;
        int vs0;
        int vs1;
        int ws0;
        int ws1;
        mode = masked_pwm_pkg::pwm_mode_e'(vec_mem[idx*n_cols][0]);
        split_share(int'(vec_mem[idx*n_cols+1]), us0, us1);
        split_share(int'(vec_mem[idx*n_cols+2]), vs0, vs1);
        split_share(int'(vec_mem[idx*n_cols+3]), ws0, ws1);
        // raw 23-bit words, so some rnd values lie at or above q
        draw_random(ra);
        draw_random(rb);
        @(posedge clk);
        in_valid <= 1'b1;
        accumulate <= (mode == masked_pwm_pkg::mode_pwma);
        u0 <= us0[22:0];
        u1 <= us1[22:0];
        v0 <= vs0[22:0];
        v1 <= vs1[22:0];
        w0 <= ws0[22:0];
        w1 <= ws1[22:0];
        rnd0 <= ra[22:0];
        rnd1 <= rb[22:0];
        if (keep) begin
            exp_q.push_back(int'(vec_mem[idx*n_cols+4]));
            // in_valid is seen high during the cycle after this edge
            stamp_q.push_back(cycle + 1);
            tag_q.push_back(tag);
            vec_q.push_back(idx);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic pulse_zeroize();
        @(posedge clk);
        in_valid <= 1'b0;
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
    endtask

    // the watchdog bounds this wait if an output never comes
    task automatic drain_results();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin : monitor_b
        int exp_v;
        int stamp;
        int tag;
        int idx;
        int got;
        if (reset_n && out_valid) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("out_valid rose in cycle %0d with no operation in flight", cycle);
            end else begin
                exp_v = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                tag = tag_q.pop_front();
                idx = vec_q.pop_front();
                got = (int'(res0) + int'(res1)) % q_int;
                n_checks++;
                assert (got == exp_v) else begin
                    value_errs++;
                    $display("ERR res0+res1 vector %0d: got 0x%06h expected 0x%06h (0x%06h, 0x%06h)",
                             idx, got, exp_v, res0, res1);
                end
                assert (cycle - stamp == masked_pwm_pkg::pwm_lat) else begin
                    timing_errs++;
                    $display("vector %0d came out %0d cycles after in_valid instead of %0d",
                             idx, cycle - stamp, masked_pwm_pkg::pwm_lat);
                end
                if (tag >= 0) begin
                    mask_res0[tag] = res0;
                    mask_res1[tag] = res1;
                end
            end
        end
    end

    initial begin : watchdog_b
        #(limit_cycles * clk_period);
        $display("run stopped after %0d cycles with %0d results still outstanding",
                 limit_cycles, exp_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus_b
        int i;
        int j;
        reset_n = 1'b0;
        zeroize = 1'b0;
        in_valid = 1'b0;
        accumulate = 1'b0;
        u0 = '0;
        u1 = '0;
        v0 = '0;
        v1 = '0;
        w0 = '0;
        w1 = '0;
        rnd0 = '0;
        rnd1 = '0;
        $readmemh("tests/pwm_tests.dat", vec_mem);
        for (i = 0; i < n_vec; i++) begin
            if ($isunknown(vec_mem[i*n_cols+4])) begin
                other_errs++;
                $display("vector %0d is missing or unreadable in the data file", i);
            end
        end

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        idle_cycle();

        // every vector alone with a gap, plain, accumulate and edge operands
        for (i = 0; i < n_vec; i++) begin
            send_op(i, -1, 1'b1);
            idle_cycle();
        end
        drain_results();

        // the same vectors back to back, mixed modes, one result per cycle
        for (i = 0; i < n_vec; i++) begin
            send_op(i, -1, 1'b1);
        end
        idle_cycle();
        drain_results();

        // one vector under fresh shares and rnd each time
        for (i = 0; i < mask_reps; i++) begin
            send_op(mask_vec, i, 1'b1);
        end
        idle_cycle();
        drain_results();
        for (i = 0; i < mask_reps; i++) begin
            for (j = i + 1; j < mask_reps; j++) begin
                assert (mask_res0[i] != mask_res0[j] && mask_res1[i] != mask_res1[j])
                else begin
                    other_errs++;
                    $display("output shares of masked runs %0d and %0d did not change", i, j);
                end
            end
        end

        // three items go in flight and are flushed, the monitor flags any survivor
        for (i = 0; i < 3; i++) begin
            send_op(i + 3, -1, 1'b0);
        end
        pulse_zeroize();
        repeat (2 * masked_pwm_pkg::pwm_lat) idle_cycle();
        send_op(zero_vec, -1, 1'b1);
        idle_cycle();
        drain_results();
        repeat (2) idle_cycle();

        $display("checks %0d, value errors %0d, timing errors %0d, other errors %0d",
                 n_checks, value_errs, timing_errs, other_errs);
        if (value_errs + timing_errs + other_errs == 0 && n_checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/pwm_top.sv
// masked pointwise-multiply top level with valid tracking, mode gating and zeroize
`default_nettype none

module pwm_top (
    input wire clk,
    input wire reset_n,
    input wire zeroize,
    input wire in_valid,
    input wire accumulate,
    input wire [masked_pwm_pkg::coef_w-1:0] u0,
    input wire [masked_pwm_pkg::coef_w-1:0] u1,
    input wire [masked_pwm_pkg::coef_w-1:0] v0,
    input wire [masked_pwm_pkg::coef_w-1:0] v1,
    input wire [masked_pwm_pkg::coef_w-1:0] w0,
    input wire [masked_pwm_pkg::coef_w-1:0] w1,
    input wire [masked_pwm_pkg::coef_w-1:0] rnd0,
    input wire [masked_pwm_pkg::coef_w-1:0] rnd1,
    output logic out_valid,
    output logic [masked_pwm_pkg::coef_w-1:0] res0,
    output logic [masked_pwm_pkg::coef_w-1:0] res1
);

    // mode of the item being strobed this cycle
    masked_pwm_pkg::pwm_mode_e in_mode;

    // w shares after mode gating
    logic [masked_pwm_pkg::coef_w-1:0] w0_g;
    logic [masked_pwm_pkg::coef_w-1:0] w1_g;

    // control pipeline running in step with the datapath, bit 0 is the newest item
    logic [masked_pwm_pkg::pwm_lat-1:0] valid_pipe;
    masked_pwm_pkg::pwm_mode_e mode_pipe [masked_pwm_pkg::pwm_lat];

    assign in_mode = accumulate ? masked_pwm_pkg::mode_pwma : masked_pwm_pkg::mode_pwm;

    // zero is a valid sharing of zero, so a plain multiply becomes u*v + 0
    assign w0_g = (in_mode == masked_pwm_pkg::mode_pwma) ? w0 : '0;
    assign w1_g = (in_mode == masked_pwm_pkg::mode_pwma) ? w1 : '0;

    masked_pwm pwm_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .u0(u0),
        .u1(u1),
        .v0(v0),
        .v1(v1),
        .w0(w0_g),
        .w1(w1_g),
        .rnd0(rnd0),
        .rnd1(rnd1),
        .res0(res0),
        .res1(res1)
    );

    // zeroize drops every item in flight, including one strobed in the same cycle
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            valid_pipe <= '0;
            for (int i = 0; i < masked_pwm_pkg::pwm_lat; i++) begin
                mode_pipe[i] <= masked_pwm_pkg::mode_pwm;
            end
        end else begin
            valid_pipe <= {valid_pipe[masked_pwm_pkg::pwm_lat-2:0], in_valid};
            mode_pipe[0] <= in_mode;
            for (int i = 1; i < masked_pwm_pkg::pwm_lat; i++) begin
                mode_pipe[i] <= mode_pipe[i-1];
            end
        end
    end

    assign out_valid = valid_pipe[masked_pwm_pkg::pwm_lat-1];

    // after zeroize nothing may come out until a newly strobed item has run its course
    a_zeroize_flush: assert property (
        @(posedge clk) disable iff (!reset_n)
        zeroize |=> !out_valid [*masked_pwm_pkg::pwm_lat]
    );

    // a plain multiply leaving the unit must have met a zero addend one cycle
    // earlier, which ties the w delay line to this control pipeline
    a_plain_zero_addend: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_valid && (mode_pipe[masked_pwm_pkg::pwm_lat-1] == masked_pwm_pkg::mode_pwm)
        |-> ($past(pwm_i.w0_dly[masked_pwm_pkg::mult_lat]) == '0)
            && ($past(pwm_i.w1_dly[masked_pwm_pkg::mult_lat]) == '0)
    );

endmodule

`default_nettype wire

// File: hw/masked_pwm.sv
// masked multiply-accumulate core, u*v + w on arithmetic shares with fixed latency
`default_nettype none

module masked_pwm (
    input wire clk,
    input wire reset_n,
    input wire zeroize,
    input wire [masked_pwm_pkg::coef_w-1:0] u0,
    input wire [masked_pwm_pkg::coef_w-1:0] u1,
    input wire [masked_pwm_pkg::coef_w-1:0] v0,
    input wire [masked_pwm_pkg::coef_w-1:0] v1,
    input wire [masked_pwm_pkg::coef_w-1:0] w0,
    input wire [masked_pwm_pkg::coef_w-1:0] w1,
    input wire [masked_pwm_pkg::coef_w-1:0] rnd0,
    input wire [masked_pwm_pkg::coef_w-1:0] rnd1,
    output logic [masked_pwm_pkg::coef_w-1:0] res0,
    output logic [masked_pwm_pkg::coef_w-1:0] res1
);

    // masked product shares, valid mult_lat + 1 cycles after u and v
    logic [masked_pwm_pkg::coef_w-1:0] prod0;
    logic [masked_pwm_pkg::coef_w-1:0] prod1;

    // w delay line, one stage per cycle of the masked multiplier
    // the last entry meets the product at the adder
    logic [masked_pwm_pkg::coef_w-1:0] w0_dly [masked_pwm_pkg::mult_lat+1];
    logic [masked_pwm_pkg::coef_w-1:0] w1_dly [masked_pwm_pkg::mult_lat+1];

    masked_mult mult_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .u0(u0),
        .u1(u1),
        .v0(v0),
        .v1(v1),
        .rnd0(rnd0),
        .rnd1(rnd1),
        .p0(prod0),
        .p1(prod1)
    );

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            for (int i = 0; i <= masked_pwm_pkg::mult_lat; i++) begin
                w0_dly[i] <= '0;
                w1_dly[i] <= '0;
            end
        end else begin
            w0_dly[0] <= w0;
            w1_dly[0] <= w1;
            for (int i = 1; i <= masked_pwm_pkg::mult_lat; i++) begin
                w0_dly[i] <= w0_dly[i-1];
                w1_dly[i] <= w1_dly[i-1];
            end
        end
    end

    // the adder always runs, a plain multiply just arrives here with w at zero
    // so every item leaves after the same five cycles
    masked_add add_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .a0(prod0),
        .a1(prod1),
        .b0(w0_dly[masked_pwm_pkg::mult_lat]),
        .b1(w1_dly[masked_pwm_pkg::mult_lat]),
        .s0(res0),
        .s1(res1)
    );

endmodule

`default_nettype wire

// File: hw/masked_add.sv
// registered share-wise modular adder
`default_nettype none

module masked_add (
    input wire clk,
    input wire reset_n,
    input wire zeroize,
    input wire [masked_pwm_pkg::coef_w-1:0] a0,
    input wire [masked_pwm_pkg::coef_w-1:0] a1,
    input wire [masked_pwm_pkg::coef_w-1:0] b0,
    input wire [masked_pwm_pkg::coef_w-1:0] b1,
    output logic [masked_pwm_pkg::coef_w-1:0] s0,
    output logic [masked_pwm_pkg::coef_w-1:0] s1
);

    // next value of each output share
    logic [masked_pwm_pkg::coef_w-1:0] sum0;
    logic [masked_pwm_pkg::coef_w-1:0] sum1;

    // arithmetic masking is linear, so shares add pairwise without any new randomness
    // share 0 only ever meets share 0, and share 1 only share 1
    assign sum0 = masked_pwm_pkg::mod_add(a0, b0);
    assign sum1 = masked_pwm_pkg::mod_add(a1, b1);

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            s0 <= '0;
            s1 <= '0;
        end else begin
            s0 <= sum0;
            s1 <= sum1;
        end
    end

    // the single subtract in the adder is enough only if the multiplier
    // and the w path upstream both hand over reduced shares
    a_sum_reduced: assert property (
        @(posedge clk) disable iff (!reset_n)
        (s0 < masked_pwm_pkg::q_mod) && (s1 < masked_pwm_pkg::q_mod)
    );

endmodule

`default_nettype wire

// File: hw/masked_mult.sv
// share-wise modular multiplier, cross products recombined under a fresh refresh mask
`default_nettype none

module masked_mult (
    input wire clk,
    input wire reset_n,
    input wire zeroize,
    input wire [masked_pwm_pkg::coef_w-1:0] u0,
    input wire [masked_pwm_pkg::coef_w-1:0] u1,
    input wire [masked_pwm_pkg::coef_w-1:0] v0,
    input wire [masked_pwm_pkg::coef_w-1:0] v1,
    input wire [masked_pwm_pkg::coef_w-1:0] rnd0,
    input wire [masked_pwm_pkg::coef_w-1:0] rnd1,
    output logic [masked_pwm_pkg::coef_w-1:0] p0,
    output logic [masked_pwm_pkg::coef_w-1:0] p1
);

    // the four cross products, each ready mult_lat cycles after the operands
    logic [masked_pwm_pkg::coef_w-1:0] p00;
    logic [masked_pwm_pkg::coef_w-1:0] p01;
    logic [masked_pwm_pkg::coef_w-1:0] p10;
    logic [masked_pwm_pkg::coef_w-1:0] p11;

    // mask path, three registers deep to line up with the products
    // first the raw random words are reduced, then summed, then held
    logic [masked_pwm_pkg::coef_w-1:0] rr0_q;
    logic [masked_pwm_pkg::coef_w-1:0] rr1_q;
    logic [masked_pwm_pkg::coef_w-1:0] r_sum_q;
    logic [masked_pwm_pkg::coef_w-1:0] r_q;

    // partial sums for the combine register
    logic [masked_pwm_pkg::coef_w-1:0] row0;
    logic [masked_pwm_pkg::coef_w-1:0] row1;

    // row 0 gives u0*v and row 1 gives u1*v, together u*v
    mod_mult mul00_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .a(u0),
        .b(v0),
        .p(p00)
    );

    mod_mult mul01_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .a(u0),
        .b(v1),
        .p(p01)
    );

    mod_mult mul10_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .a(u1),
        .b(v0),
        .p(p10)
    );

    mod_mult mul11_i (
        .clk(clk),
        .reset_n(reset_n),
        .zeroize(zeroize),
        .a(u1),
        .b(v1),
        .p(p11)
    );

    // each row mixes both shares of v, so the mask must land before the row leaves
    assign row0 = masked_pwm_pkg::mod_add(p00, p01);
    assign row1 = masked_pwm_pkg::mod_add(p10, p11);

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            rr0_q <= '0;
            rr1_q <= '0;
            r_sum_q <= '0;
            r_q <= '0;
            p0 <= '0;
            p1 <= '0;
        end else begin
            // random words may reach 2^23 - 1, one subtract brings them below q
            rr0_q <= masked_pwm_pkg::mod_add(rnd0, '0);
            rr1_q <= masked_pwm_pkg::mod_add(rnd1, '0);
            r_sum_q <= masked_pwm_pkg::mod_add(rr0_q, rr1_q);
            r_q <= r_sum_q;

            // r is added to one share and taken from the other
            // so the sum mod q is still u*v while each share is uniformly masked
            p0 <= masked_pwm_pkg::mod_add(row0, r_q);
            p1 <= masked_pwm_pkg::mod_sub(row1, r_q);
        end
    end

endmodule

`default_nettype wire

// File: hw/mod_mult.sv
// three-stage pipelined modular multiplier, barrett reduction modulo q
`default_nettype none

module mod_mult (
    input wire clk,
    input wire reset_n,
    input wire zeroize,
    input wire [masked_pwm_pkg::coef_w-1:0] a,
    input wire [masked_pwm_pkg::coef_w-1:0] b,
    output logic [masked_pwm_pkg::coef_w-1:0] p
);

    // stage one holds the full product, always below q squared and so below 2^46
    logic [2*masked_pwm_pkg::coef_w-1:0] prod_q;

    // stage two carries the product forward next to its quotient estimate
    logic [2*masked_pwm_pkg::coef_w-1:0] prod_d;
    logic [masked_pwm_pkg::coef_w:0] quot_q;

    // product times the barrett constant, 46 plus 24 bits
    logic [3*masked_pwm_pkg::coef_w:0] quot_wide;

    // remainder before and after the single correction
    logic [masked_pwm_pkg::coef_w:0] rem;
    logic [masked_pwm_pkg::coef_w:0] rem_fix;

    // with the full 46-bit shift the estimate is at most one below the true quotient
    assign quot_wide = prod_q * masked_pwm_pkg::barrett_m;

    // the true remainder lies in [0, 2q), which is below 2^24
    // so the subtract only needs its low 24 bits and may wrap above them
    assign rem = prod_d[masked_pwm_pkg::coef_w:0] - quot_q * masked_pwm_pkg::q_mod;
    assign rem_fix = rem - masked_pwm_pkg::q_mod;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize) begin
            prod_q <= '0;
            prod_d <= '0;
            quot_q <= '0;
            p <= '0;
        end else begin
            // stage one, wide product
            prod_q <= a * b;

            // stage two, quotient estimate from the top bits of product times m
            prod_d <= prod_q;
            quot_q <= quot_wide[masked_pwm_pkg::barrett_k +: masked_pwm_pkg::coef_w+1];

            // stage three, one conditional subtract leaves p below q
            if (rem >= masked_pwm_pkg::q_mod) begin
                p <= rem_fix[masked_pwm_pkg::coef_w-1:0];
            end else begin
                p <= rem[masked_pwm_pkg::coef_w-1:0];
            end
        end
    end

    // the error bound of the estimate holds only for reduced operands
    // every share reaching the multipliers must already be below q
    a_operands_reduced: assert property (
        @(posedge clk) disable iff (!reset_n)
        (a < masked_pwm_pkg::q_mod) && (b < masked_pwm_pkg::q_mod)
    );

endmodule

`default_nettype wire

// File: hw/masked_pwm_pkg.sv
// masked pointwise-multiply shared constants, operation modes and modular helpers
`default_nettype none

package masked_pwm_pkg;

    // coefficient width and the prime modulus q = 2^23 - 2^13 + 1
    localparam int coef_w = 23;
    localparam logic [coef_w-1:0] q_mod = 23'd8380417;

    // barrett reduction uses the full 46-bit shift, m is floor(2^46 / q)
    localparam int barrett_k = 46;
    localparam logic [coef_w:0] barrett_m = 24'd8396807;

    // pipeline depths of the modular multiplier and of the whole unit
    localparam int mult_lat = 3;
    localparam int pwm_lat = 5;

    // plain multiply or multiply with accumulate
    typedef enum logic {
        mode_pwm = 1'b0,
        mode_pwma = 1'b1
    } pwm_mode_e;

    // sum of two values below q, brought back below q with one subtract
    function automatic logic [coef_w-1:0] mod_add(
        input logic [coef_w-1:0] a,
        input logic [coef_w-1:0] b
    );
        logic [coef_w:0] sum;
        logic [coef_w:0] sum_fix;
        sum = a + b;
        sum_fix = sum - q_mod;
        return (sum >= q_mod) ? sum_fix[coef_w-1:0] : sum[coef_w-1:0];
    endfunction

    // difference of two values below q, lifted by q when it would go negative
    function automatic logic [coef_w-1:0] mod_sub(
        input logic [coef_w-1:0] a,
        input logic [coef_w-1:0] b
    );
        return (a >= b) ? (a - b) : (a + (q_mod - b));
    endfunction

endpackage

`default_nettype wire
